//--- list.f
hdl/dp_lane_pkg.sv
hdl/dp_rx_descrambler.sv
hdl/dp_rx_blank_tracker.sv
hdl/dp_rx_lane_regs.sv
hdl/dp_rx_lane_top.sv
dv/dp_rx_lane_props.sv
dv/dp_rx_lane_tb.sv

//--- Bender.yml
package:
  name: dp_rx_lane

sources:
  - hdl/dp_lane_pkg.sv
  - hdl/dp_rx_descrambler.sv
  - hdl/dp_rx_blank_tracker.sv
  - hdl/dp_rx_lane_regs.sv
  - hdl/dp_rx_lane_top.sv
  - target: test
    files:
      - dv/dp_rx_lane_props.sv
      - dv/dp_rx_lane_tb.sv

//--- dv/dp_rx_lane_tb.sv
// Directed testbench for the DisplayPort RX lane top that runs from list.f as top dp_rx_lane_tb
`default_nettype none
`timescale 1ns/1ps

module dp_rx_lane_tb;

    import dp_lane_pkg::*;

    localparam int P_SPL    = 2;
    localparam int P_BEAT_W = P_SPL * 9;

    // Cycle budget per test plus slack
    localparam int P_LEN_RESET   = 12;
    localparam int P_LEN_BYPASS  = 30;
    localparam int P_LEN_DESCR   = 40;
    localparam int P_LEN_WDG     = 80;
    localparam int P_LEN_BLANK   = 30;
    localparam int P_LEN_MARGIN  = 100;
    localparam int P_CYCLE_LIMIT = P_LEN_RESET + P_LEN_BYPASS + P_LEN_DESCR
                                 + P_LEN_WDG + P_LEN_BLANK + P_LEN_MARGIN;

    // DUT side
    logic      CLK_IN;
    logic      RST_IN;
    logic      lock_in;
    sym_t      sym_in [0:P_SPL-1];
    logic      reg_wr;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    sym_t      sym_out [0:P_SPL-1];
    logic      lock;
    logic      blank;
    reg_data_t reg_rdata;

    // Plain beat filled by the tests and scrambled on the way in
    sym_t beat_buf [0:P_SPL-1];

    // Reference scrambler state and SR just seen
    lfsr_t ref_lfsr;
    logic  ref_sr_prev;
    // Mirrors the descramble enable
    logic  scr_on;
    logic  blank_model;
    int    sr_beats;
    int    bs_beats;

    // Expected output beats one clock behind the input
    logic [P_BEAT_W-1:0] exp_q [$];

    int cycle_cnt = 0;
    int check_cnt = 0;
    int err_cnt   = 0;
    int test_cnt  = 0;

    dp_rx_lane_top #(
        .P_SPL     (P_SPL)
    ) dut (
        .CLK_IN    (CLK_IN),
        .RST_IN    (RST_IN),
        .lock_in   (lock_in),
        .sym_in    (sym_in),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .sym_out   (sym_out),
        .lock      (lock),
        .blank     (blank),
        .reg_rdata (reg_rdata)
    );

    // 40 ns clock
    always #20 CLK_IN = ~CLK_IN;

    // Run limit
    always @(posedge CLK_IN)
    begin
        cycle_cnt++;
        if (cycle_cnt > P_CYCLE_LIMIT)
        begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    // Eight shifts of x^16 + x^5 + x^4 + x^3 + 1 per symbol
    function automatic lfsr_t lfsr_advance(input lfsr_t cur);
        lfsr_t nxt;
        logic  msb;
        nxt = cur;
        for (int k = 0; k < 8; k++)
        begin
            msb    = nxt[15];
            nxt    = nxt << 1;
            nxt[0] = msb;
            nxt[3] = nxt[3] ^ msb;
            nxt[4] = nxt[4] ^ msb;
            nxt[5] = nxt[5] ^ msb;
        end
        return nxt;
    endfunction

    // Key byte with the top LFSR bit in bit 0
    function automatic logic [7:0] key_byte(input lfsr_t cur);
        logic [7:0] key;
        for (int k = 0; k < 8; k++)
        begin
            key[k] = cur[15-k];
        end
        return key;
    endfunction

    // Random symbol with K codes at the given percentage
    function automatic sym_t rand_sym(input int k_pct);
        sym_t        s;
        logic [31:0] r;
        r = $urandom;
        s = {1'b0, r[7:0]};
        if (($urandom % 100) < k_pct)
        begin
            case ($urandom % 5)
                0:       s = P_SYM_SR;
                1:       s = P_SYM_BS;
                2:       s = P_SYM_BE;
                3:       s = 9'h13C;
                default: s = 9'h15C;
            endcase
        end
        return s;
    endfunction

    task automatic compare_sym(input string name, input sym_t exp, input sym_t act);
        check_cnt++;
        if (act !== exp)
        begin
            $display("CHECK FAILED time %0t: %s expected %h got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp)
        begin
            $display("CHECK FAILED time %0t: %s expected %b got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_reg(input string name, input reg_data_t exp, input reg_data_t act);
        check_cnt++;
        if (act !== exp)
        begin
            $display("CHECK FAILED time %0t: %s expected %h got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // Scramble beat_buf into sym_in and check the beat one clock later
    task automatic drive_beat();
        logic [P_BEAT_W-1:0] exp_beat;
        logic                any_sr;
        logic                any_bs;
        sym_t                s;
        sym_t                e;
        any_sr = 1'b0;
        any_bs = 1'b0;
        for (int i = 0; i < P_SPL; i++)
        begin
            s = beat_buf[i];
            // Symbol after an SR starts from the seed
            if (ref_sr_prev)
                ref_lfsr = P_LFSR_SEED;
            else
                ref_lfsr = lfsr_advance(ref_lfsr);
            ref_sr_prev = (s == P_SYM_SR);
            e = ref_sr_prev ? P_SYM_BS : s;
            any_sr = any_sr | ref_sr_prev;
            any_bs = any_bs | (e == P_SYM_BS);
            if (scr_on && !s[8])
                sym_in[i] = {1'b0, s[7:0] ^ key_byte(ref_lfsr)};
            else
                sym_in[i] = s;
            exp_beat[i*9 +: 9] = e;
        end
        exp_q.push_back(exp_beat);
        sr_beats += any_sr;
        bs_beats += any_bs;
        @(posedge CLK_IN);
        #2;
        exp_beat = exp_q.pop_front();
        for (int i = 0; i < P_SPL; i++)
        begin
            compare_sym($sformatf("sym_out[%0d]", i), exp_beat[i*9 +: 9], sym_out[i]);
        end
        // Blank still shows the beats before this one
        compare_bit("blank", blank_model, blank);
        for (int i = 0; i < P_SPL; i++)
        begin
            if (exp_beat[i*9 +: 9] == P_SYM_BS)
                blank_model = 1'b1;
            else if (exp_beat[i*9 +: 9] == P_SYM_BE)
                blank_model = 1'b0;
        end
    endtask

    task automatic fill_random_beat(input int k_pct);
        for (int i = 0; i < P_SPL; i++)
        begin
            beat_buf[i] = rand_sym(k_pct);
        end
    endtask

    task automatic load_pair(input sym_t first, input sym_t second);
        beat_buf[0] = first;
        beat_buf[1] = second;
    endtask

    task automatic idle_beat();
        for (int i = 0; i < P_SPL; i++)
        begin
            beat_buf[i] = 9'h000;
        end
        drive_beat();
    endtask

    // Write strobe for exactly one edge
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        idle_beat();
        reg_wr    = 1'b0;
        if (addr == P_REG_CTRL)
            scr_on = data[0];
    endtask

    // Read data is valid one clock after the address
    task automatic read_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_addr = addr;
        idle_beat();
        compare_reg(name, exp, reg_rdata);
    endtask

    task automatic report_test(input string name, input int first_err);
        test_cnt++;
        $display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - first_err);
    endtask

    task automatic reset_values();
        int first_err;
        first_err = err_cnt;
        read_reg(P_REG_CTRL, 32'h0000_0000, "reg_rdata ctrl");
        read_reg(P_REG_WDG, 32'h00FF_FFFF, "reg_rdata wdg");
        read_reg(P_REG_STAT, 32'h0000_0001, "reg_rdata stat");
        read_reg(P_REG_CNT, 32'h0000_0000, "reg_rdata cnt");
        compare_bit("lock", 1'b1, lock);
        compare_bit("blank", 1'b0, blank);
        report_test("reset values", first_err);
    endtask

    task automatic bypass_path();
        int first_err;
        first_err = err_cnt;
        for (int n = 0; n < 24; n++)
        begin
            fill_random_beat(20);
            // SR in each slot in turn
            if ((n % 6) == 2)
                beat_buf[(n / 6) % P_SPL] = P_SYM_SR;
            drive_beat();
        end
        report_test("bypass", first_err);
    endtask

    task automatic descramble_path();
        int first_err;
        first_err = err_cnt;
        write_reg(P_REG_CTRL, 32'h1);
        for (int p = 0; p < P_SPL; p++)
        begin
            fill_random_beat(0);
            beat_buf[p] = P_SYM_SR;
            drive_beat();
            for (int n = 0; n < 12; n++)
            begin
                fill_random_beat(15);
                drive_beat();
            end
        end
        report_test("descramble", first_err);
    endtask

    task automatic watchdog_lock();
        int first_err;
        int waited;
        first_err = err_cnt;
        write_reg(P_REG_WDG, 32'd20);
        write_reg(P_REG_STAT, 32'h2);
        // SR every eight beats inside the reload
        for (int r = 0; r < 5; r++)
        begin
            for (int n = 0; n < 8; n++)
            begin
                fill_random_beat(0);
                if (n == 7)
                    beat_buf[0] = P_SYM_SR;
                drive_beat();
                compare_bit("lock", 1'b1, lock);
            end
        end
        // SR stops here
        waited = 0;
        while ((lock === 1'b1) && (waited < 22))
        begin
            idle_beat();
            waited++;
        end
        if (lock !== 1'b0)
        begin
            $display("Error time %0t: lock still high %0d clocks after the last SR", $time, waited);
            err_cnt++;
        end
        else if (waited < 20)
        begin
            $display("Error time %0t: lock fell %0d clocks after the last SR, too early", $time,
                     waited);
            err_cnt++;
        end
        // Sticky flag follows the drop by a clock
        idle_beat();
        read_reg(P_REG_STAT, {29'd0, blank_model, 2'b10}, "reg_rdata stat");
        write_reg(P_REG_STAT, 32'h2);
        read_reg(P_REG_STAT, {29'd0, blank_model, 2'b00}, "reg_rdata stat");
        // No reload from an SR while the lane is unaligned
        lock_in = 1'b0;
        fill_random_beat(0);
        beat_buf[0] = P_SYM_SR;
        drive_beat();
        idle_beat();
        compare_bit("lock", 1'b0, lock);
        lock_in = 1'b1;
        report_test("watchdog", first_err);
    endtask

    task automatic blanking_and_counts();
        int first_err;
        first_err = err_cnt;
        load_pair(P_SYM_BS, rand_sym(0));
        drive_beat();
        idle_beat();
        compare_bit("blank", 1'b1, blank);
        for (int n = 0; n < 2; n++)
        begin
            fill_random_beat(0);
            drive_beat();
        end
        compare_bit("blank", 1'b1, blank);
        load_pair(rand_sym(0), P_SYM_BE);
        drive_beat();
        idle_beat();
        compare_bit("blank", 1'b0, blank);
        // Both codes in one beat where the later slot decides
        load_pair(P_SYM_BE, P_SYM_BS);
        drive_beat();
        idle_beat();
        compare_bit("blank", 1'b1, blank);
        load_pair(P_SYM_BS, P_SYM_BE);
        drive_beat();
        idle_beat();
        compare_bit("blank", 1'b0, blank);
        // Let the last BS pulse reach the counter
        idle_beat();
        idle_beat();
        read_reg(P_REG_CNT, {bs_beats[15:0], sr_beats[15:0]}, "reg_rdata cnt");
        report_test("blanking and counters", first_err);
    endtask

    initial
    begin
        void'($urandom(17668));
        CLK_IN      = 1'b0;
        RST_IN      = 1'b1;
        lock_in     = 1'b1;
        reg_wr      = 1'b0;
        reg_addr    = P_REG_CTRL;
        reg_wdata   = '0;
        for (int i = 0; i < P_SPL; i++)
        begin
            sym_in[i]   = 9'h000;
            beat_buf[i] = 9'h000;
        end
        ref_lfsr    = P_LFSR_SEED;
        ref_sr_prev = 1'b0;
        scr_on      = 1'b0;
        blank_model = 1'b0;
        sr_beats    = 0;
        bs_beats    = 0;
        repeat (4) @(posedge CLK_IN);
        #2;
        RST_IN = 1'b0;
        // Every clock carries a modelled beat
        reset_values();
        bypass_path();
        descramble_path();
        watchdog_lock();
        blanking_and_counts();
        // Failed concurrent assertions in the bound checker
        err_cnt += dut.u_descrambler.u_props.fail_cnt;
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/dp_rx_lane_props.sv
// Concurrent checks on the lane descrambler attached to every descrambler instance by bind
`default_nettype none
`timescale 1ns/1ps

module dp_rx_descrambler_props
#(
    // Symbols per clock from the bound instance
    parameter int P_SPL = 2
)
(
    input  wire                      CLK_IN,
    input  wire                      RST_IN,
    input  wire                      descr_en,
    input  wire                      lock,
    input  wire dp_lane_pkg::sym_t   sym_in [0:P_SPL-1],
    input  wire dp_lane_pkg::sym_t   sym_out [0:P_SPL-1]
);

    import dp_lane_pkg::*;

    // Count of failed assertions
    int fail_cnt = 0;

    // Bypass forces lock high on the next clock
    assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !descr_en |=> lock)
    else
    begin
        fail_cnt++;
        $error("lock low one clock after descr_en was clear");
    end

    for (genvar i = 0; i < P_SPL; i++)
    begin : g_pos
        // SR leaves as BS in the same slot
        assert property (@(posedge CLK_IN) disable iff (RST_IN)
            (sym_in[i] == P_SYM_SR) |=> (sym_out[i] == P_SYM_BS))
        else
        begin
            fail_cnt++;
            $error("SR in slot %0d not replaced by BS", i);
        end

        // Any other K code untouched by the scrambler
        assert property (@(posedge CLK_IN) disable iff (RST_IN)
            (sym_in[i][8] && (sym_in[i] != P_SYM_SR)) |=> (sym_out[i] == $past(sym_in[i])))
        else
        begin
            fail_cnt++;
            $error("K symbol in slot %0d changed on its way through", i);
        end
    end

endmodule

// Attach to each descrambler
bind dp_rx_descrambler dp_rx_descrambler_props #(
    .P_SPL    (P_SPL)
) u_props (
    .CLK_IN   (CLK_IN),
    .RST_IN   (RST_IN),
    .descr_en (descr_en),
    .lock     (lock),
    .sym_in   (sym_in),
    .sym_out  (sym_out)
);

`default_nettype wire

//--- hdl/dp_rx_lane_top.sv
// DisplayPort RX lane top joining descrambler, blanking tracker and register block; the DUT level
`default_nettype none
`timescale 1ns/1ps

module dp_rx_lane_top
#(
    // Symbols per clock, 1, 2 or 4
    parameter int P_SPL = 2
)
(
    input  wire                          CLK_IN,
    input  wire                          RST_IN,

    // Aligned lane
    input  wire                          lock_in,
    input  wire dp_lane_pkg::sym_t       sym_in [0:P_SPL-1],

    // Register bus
    input  wire                          reg_wr,
    input  wire dp_lane_pkg::reg_addr_t  reg_addr,
    input  wire dp_lane_pkg::reg_data_t  reg_wdata,

    // Descrambled lane and status
    output dp_lane_pkg::sym_t            sym_out [0:P_SPL-1],
    output logic                         lock,
    output logic                         blank,
    output dp_lane_pkg::reg_data_t       reg_rdata
);

    import dp_lane_pkg::*;

    // Control from the registers
    logic descr_en;
    wdg_t wdg_reload;

    // Event pulses into the counters
    logic sr_seen;
    logic bs_seen;

    // Descrambler
    dp_rx_descrambler #(
        .P_SPL      (P_SPL)
    ) u_descrambler (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .descr_en   (descr_en),
        .wdg_reload (wdg_reload),
        .lock_in    (lock_in),
        .sym_in     (sym_in),
        .sym_out    (sym_out),
        .lock       (lock),
        .sr_seen    (sr_seen)
    );

    // Blanking on the descrambled output
    dp_rx_blank_tracker #(
        .P_SPL      (P_SPL)
    ) u_blank_tracker (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .sym_in     (sym_out),
        .blank      (blank),
        .bs_seen    (bs_seen)
    );

    // Registers
    dp_rx_lane_regs u_lane_regs (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .descr_en   (descr_en),
        .wdg_reload (wdg_reload),
        .lock       (lock),
        .blank      (blank),
        .sr_seen    (sr_seen),
        .bs_seen    (bs_seen)
    );

endmodule

`default_nettype wire

//--- hdl/dp_rx_lane_regs.sv
// Lane control and status registers, steering the descrambler and counting events; used by the lane top
`default_nettype none
`timescale 1ns/1ps

module dp_rx_lane_regs
(
    input  wire                          CLK_IN,
    input  wire                          RST_IN,

    // Register bus, single cycle write strobe
    input  wire                          reg_wr,
    input  wire dp_lane_pkg::reg_addr_t  reg_addr,
    input  wire dp_lane_pkg::reg_data_t  reg_wdata,
    output dp_lane_pkg::reg_data_t       reg_rdata,

    // Descrambler control
    output logic                         descr_en,
    output dp_lane_pkg::wdg_t            wdg_reload,

    // Status inputs
    input  wire                          lock,
    input  wire                          blank,
    input  wire                          sr_seen,
    input  wire                          bs_seen
);

    import dp_lane_pkg::*;

    // Lock of the previous clock, for edge detect
    logic        lock_q;

    // Sticky lock lost
    logic        lock_lost;

    // Event counters, saturating
    logic [15:0] sr_cnt;
    logic [15:0] bs_cnt;

    // Write decode
    logic        wr_ctrl;
    logic        wr_wdg;
    logic        wr_stat;

    assign wr_ctrl = reg_wr && (reg_addr == P_REG_CTRL);
    assign wr_wdg  = reg_wr && (reg_addr == P_REG_WDG);
    assign wr_stat = reg_wr && (reg_addr == P_REG_STAT);

    // Control and watchdog reload
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            descr_en   <= 1'b0;
            wdg_reload <= '1;
        end
        else
        begin
            if (wr_ctrl)
                descr_en <= reg_wdata[0];
            if (wr_wdg)
                wdg_reload <= reg_wdata[P_WDG_W-1:0];
        end
    end

    // Sticky flag, a new falling edge wins over a clear
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            lock_q    <= 1'b1;
            lock_lost <= 1'b0;
        end
        else
        begin
            lock_q <= lock;
            if (lock_q && !lock)
                lock_lost <= 1'b1;
            else if (wr_stat && reg_wdata[1])
                lock_lost <= 1'b0;
        end
    end

    // SR and BS beat counters, stop at all ones
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            sr_cnt <= '0;
            bs_cnt <= '0;
        end
        else
        begin
            if (sr_seen && (sr_cnt != '1))
                sr_cnt <= sr_cnt + 1'b1;
            if (bs_seen && (bs_cnt != '1))
                bs_cnt <= bs_cnt + 1'b1;
        end
    end

    // Read mux, registered
    always_ff @(posedge CLK_IN)
    begin
        case (reg_addr)
            P_REG_CTRL: reg_rdata <= {31'd0, descr_en};
            P_REG_WDG:  reg_rdata <= {{(32-P_WDG_W){1'b0}}, wdg_reload};
            P_REG_STAT: reg_rdata <= {29'd0, blank, lock_lost, lock};
            default:    reg_rdata <= {bs_cnt, sr_cnt};
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/dp_rx_blank_tracker.sv
// Blanking level tracker on the descrambled stream with a BS pulse; instantiated by the lane top
`default_nettype none
`timescale 1ns/1ps

module dp_rx_blank_tracker
#(
    // Symbols per clock
    parameter int P_SPL = 2
)
(
    input  wire                      CLK_IN,
    input  wire                      RST_IN,

    // Descrambled symbols
    input  wire dp_lane_pkg::sym_t   sym_in [0:P_SPL-1],

    // Blanking level, one clock after the beat
    output logic                     blank,

    // Beat holds at least one BS
    output logic                     bs_seen
);

    import dp_lane_pkg::*;

    // Level after scanning this beat
    logic blank_nxt;

    // BS anywhere in this beat
    logic bs_any;

    // Scan in symbol order, later symbols override earlier ones
    always_comb
    begin
        blank_nxt = blank;
        bs_any    = 1'b0;
        for (int i = 0; i < P_SPL; i++)
        begin
            if (sym_in[i] == P_SYM_BS)
            begin
                blank_nxt = 1'b1;
                bs_any    = 1'b1;
            end
            else if (sym_in[i] == P_SYM_BE)
            begin
                blank_nxt = 1'b0;
            end
        end
    end

    // Combinational pulse towards the counters
    assign bs_seen = bs_any;

    // Blanking level
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            blank <= 1'b0;
        else
            blank <= blank_nxt;
    end

endmodule

`default_nettype wire

//--- hdl/dp_rx_descrambler.sv
// Lane descrambler with SR to BS substitution and SR watchdog lock; instantiated by the lane top
`default_nettype none
`timescale 1ns/1ps

module dp_rx_descrambler
#(
    // Symbols per clock
    parameter int P_SPL = 2
)
(
    input  wire                      CLK_IN,
    input  wire                      RST_IN,

    // Control from the register block
    input  wire                      descr_en,
    input  wire dp_lane_pkg::wdg_t   wdg_reload,

    // Alignment lock from the upstream stage
    input  wire                      lock_in,

    // Symbol stream
    input  wire dp_lane_pkg::sym_t   sym_in [0:P_SPL-1],
    output dp_lane_pkg::sym_t        sym_out [0:P_SPL-1],

    // Status
    output logic                     lock,
    output logic                     sr_seen
);

    import dp_lane_pkg::*;

    // Advance the scrambler by one byte, eight serial steps
    function automatic lfsr_t lfsr_step(input lfsr_t lfsr_cur);
        lfsr_t s;
        logic  fb;
        s = lfsr_cur;
        for (int n = 0; n < 8; n++)
        begin
            fb = s[15];
            // Shift up, feedback into bit 0 and the taps
            s = {s[14:0], 1'b0} ^ (fb ? P_LFSR_POLY : '0);
        end
        return s;
    endfunction

    // Scrambling byte, high LFSR byte with bit order reversed
    function automatic logic [7:0] scr_byte(input lfsr_t lfsr_cur);
        logic [7:0] b;
        for (int j = 0; j < 8; j++)
        begin
            b[j] = lfsr_cur[15-j];
        end
        return b;
    endfunction

    // Per symbol SR flags
    logic [P_SPL-1:0] sr_det;

    // Symbols with SR already replaced by BS
    sym_t             dat [0:P_SPL-1];

    // LFSR chain across the beat
    logic [P_SPL-1:0] lfsr_rst;
    lfsr_t            lfsr_in [0:P_SPL-1];
    lfsr_t            lfsr [0:P_SPL-1];

    // State carried into the next beat
    lfsr_t            lfsr_q;
    logic             lfsr_rst_q;

    // Watchdog
    wdg_t             wdg_cnt;
    logic             wdg_end;

    // SR detection and BS substitution
    always_comb
    begin
        for (int i = 0; i < P_SPL; i++)
        begin
            sr_det[i] = (sym_in[i] == P_SYM_SR);
            dat[i]    = sr_det[i] ? P_SYM_BS : sym_in[i];
        end
    end

    // Any SR in this beat
    assign sr_seen = |sr_det;

    // Reset of each chain step
    // First position restarts from an SR at the end of the previous beat
    // Others restart from an SR just before them in this beat
    always_comb
    begin
        lfsr_rst[0] = lfsr_rst_q;
        for (int i = 1; i < P_SPL; i++)
        begin
            lfsr_rst[i] = sr_det[i-1];
        end
    end

    // Chain inputs, first from the register, others from the previous step
    always_comb
    begin
        lfsr_in[0] = lfsr_q;
        for (int i = 1; i < P_SPL; i++)
        begin
            lfsr_in[i] = lfsr[i-1];
        end
    end

    // One LFSR step per symbol position
    always_comb
    begin
        for (int i = 0; i < P_SPL; i++)
        begin
            if (lfsr_rst[i])
                lfsr[i] = P_LFSR_SEED;
            else
                lfsr[i] = lfsr_step(lfsr_in[i]);
        end
    end

    // Carry LFSR state and the trailing SR into the next beat
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            lfsr_q     <= P_LFSR_SEED;
            lfsr_rst_q <= 1'b0;
        end
        else
        begin
            lfsr_q     <= lfsr[P_SPL-1];
            lfsr_rst_q <= sr_det[P_SPL-1];
        end
    end

    // Output register, one clock latency in both modes
    always_ff @(posedge CLK_IN)
    begin
        for (int i = 0; i < P_SPL; i++)
        begin
            // K symbols and bypass pass as they are
            if (descr_en && !dat[i][8])
                sym_out[i] <= {1'b0, dat[i][7:0] ^ scr_byte(lfsr[i])};
            else
                sym_out[i] <= dat[i];
        end
    end

    // Watchdog, reloaded by SR while the lane is aligned
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            wdg_cnt <= '0;
        else if (!lock_in)
            wdg_cnt <= '0;
        else if (sr_seen)
            wdg_cnt <= wdg_reload;
        else if (!wdg_end)
            wdg_cnt <= wdg_cnt - 1'b1;
    end

    // Expired
    assign wdg_end = (wdg_cnt == '0);

    // Lock level, forced high while descrambling is off
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lock <= 1'b1;
        else if (descr_en)
            lock <= !wdg_end;
        else
            lock <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/dp_lane_pkg.sv
// Shared symbol codes, LFSR constants and register map for the DisplayPort RX lane; import where needed
`default_nettype none

package dp_lane_pkg;

    // One link symbol, K flag in bit 8 above the data byte
    typedef logic [8:0] sym_t;

    // Control symbols after 8b/10b decode
    // K28.0 scrambler reset
    localparam sym_t P_SYM_SR = 9'h11C;
    // K28.5 blanking start
    localparam sym_t P_SYM_BS = 9'h1BC;
    // K27.7 blanking end
    localparam sym_t P_SYM_BE = 9'h1FB;

    // Scrambler LFSR state, x^16 + x^5 + x^4 + x^3 + 1
    typedef logic [15:0] lfsr_t;

    // State loaded after every SR
    localparam lfsr_t P_LFSR_SEED = 16'hFFFF;

    // Feedback mask of one serial step, bit 0 plus taps 3, 4 and 5
    localparam lfsr_t P_LFSR_POLY = 16'h0039;

    // Watchdog counter
    localparam int P_WDG_W = 24;
    typedef logic [P_WDG_W-1:0] wdg_t;

    // Register bus
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Control, bit 0 descramble enable
    localparam reg_addr_t P_REG_CTRL = 2'd0;
    // Watchdog reload value
    localparam reg_addr_t P_REG_WDG  = 2'd1;
    // Status, bit 0 lock, bit 1 sticky lock lost (W1C), bit 2 blanking
    localparam reg_addr_t P_REG_STAT = 2'd2;
    // SR count low half, BS count high half
    localparam reg_addr_t P_REG_CNT  = 2'd3;

endpackage

`default_nettype wire
